// File: tb/coreInput.txt
# Columns: kind (W write, R read), address, data, response (0 OKAY, 2 SLVERR)
# W data is the word pushed; R data is the expected register or count value
W 00 B8101234 0
W 00 B820FFFB 0
W 00 B83000F0 0
W 00 B8408000 0
R 08 0000000000001234 0
R 10 FFFFFFFFFFFFFFFB 0
R 18 00000000000000F0 0
R 20 FFFFFFFFFFFF8000 0
R 80 0000000000000004 0
W 00 B8500010 0
W 00 01510000 0
W 00 29310000 0
W 00 B8600F0F 0
W 00 21610000 0
W 00 B87000FF 0
W 00 09710000 0
W 00 B880FFFF 0
W 00 31810000 0
W 00 0591FFCC 0
W 00 C1A10024 0
W 00 C1B10044 0
R 28 0000000000001244 0
R 18 FFFFFFFFFFFFEEBC 0
R 30 0000000000000204 0
R 38 00000000000012FF 0
R 40 FFFFFFFFFFFFEDCB 0
R 48 0000000000001200 0
R 50 0001234000000000 0
R 58 0000000000012340 0
W 00 B8C00003 0
W 00 05CC0005 0
W 00 C1DC0002 0
W 00 01DC0000 0
W 00 29CD0000 0
W 00 31DC0000 0
R 60 FFFFFFFFFFFFFFE0 0
R 68 FFFFFFFFFFFFFFC8 0
W 08 B8107777 2
W 00 FF1F0001 0
W 00 7AF00042 0
R 08 0000000000001234 0
R 78 0000000000000000 0
R 04 0000000000000000 2
R 88 0000000000000000 2
R 84 0000000000000000 2
R 80 0000000000000016 0

// File: all.f
+incdir+source
source/corePkg.sv
source/hostPort.sv
source/decodeStage.sv
source/executeStage.sv
source/writeBack.sv
source/core.sv
tb/clockGen.sv
tb/coreTb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" \
   && verilator --binary --timing --timescale 1ns/1ps --top-module coreTb -f all.f -o simCore \
   && ./obj_dir/simCore | tee /dev/stderr | grep -qx "Result: PASSED" \
   && echo "Simulation passed" \
   || { echo "Simulation failed"; exit 1; }

// File: tb/coreTb.sv
// Core testbench
`timescale 1ns/1ps
`default_nettype none

`include "coreSettings.svh"

module coreTb
   import corePkg::*;
();

   logic                     bus;
   logic                     rst;
   axiAddr_t                 awaddr;
   logic                     awvalid;
   logic                     awready;
   regWord_t                 wdata;
   logic [`DATA_WIDTH/8-1:0] wstrb;
   logic                     wvalid;
   logic                     wready;
   axiResp_t                 bresp;
   logic                     bvalid;
   logic                     bready;
   axiAddr_t                 araddr;
   logic                     arvalid;
   logic                     arready;
   regWord_t                 rdata;
   axiResp_t                 rresp;
   logic                     rvalid;
   logic                     rready;

   byte      cmdKind [$];
   axiAddr_t cmdAddr [$];
   regWord_t cmdData [$];
   axiResp_t cmdResp [$];

   int testErrors  = 0;
   int failedTests = 0;
   int cycles      = 0;
   int cycleLimit  = 1000000; // Replaced once the commands are loaded

   clockGen clocks (.bus(bus), .rst(rst));

   core UUT (
      .bus(bus), .rst(rst),
      .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
      .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
      .bresp(bresp), .bvalid(bvalid), .bready(bready),
      .araddr(araddr), .arvalid(arvalid), .arready(arready),
      .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready)
   );

   always @(posedge bus) begin
      cycles <= cycles + 1;
      if (cycles >= cycleLimit) begin
         $display("Timeout: the run went past %0d cycles", cycleLimit);
         $display("Result: FAILED");
         $finish;
      end
   end

   task automatic loadCommands(output bit ok);
      int          fd;
      int          n;
      string       line;
      byte         kind;
      logic [31:0] addr;
      logic [63:0] data;
      logic [31:0] resp;
      fd = $fopen("tb/coreInput.txt", "r");
      ok = (fd != 0);
      if (ok) begin
         while ($fgets(line, fd) != 0) begin
            if (line.len() > 1 && line[0] != "#") begin // Skip comments and blank lines
               n = $sscanf(line, "%c %h %h %h", kind, addr, data, resp);
               if (n == 4) begin
                  cmdKind.push_back(kind);
                  cmdAddr.push_back(axiAddr_t'(addr));
                  cmdData.push_back(regWord_t'(data));
                  cmdResp.push_back(axiResp_t'(resp));
               end
            end
         end
         $fclose(fd);
      end
   endtask

   task automatic checkReg(input string name, input regWord_t got, input regWord_t exp);
      if (got !== exp) begin
         $display("** Error: %s = %h, expected %h", name, got, exp);
         testErrors++;
      end
   endtask

   task automatic checkResp(input string name, input axiResp_t got, input axiResp_t exp);
      if (got !== exp) begin
         $display("** Error: %s = %h, expected %h", name, got, exp);
         testErrors++;
      end
   endtask

   task automatic idleCycles();
      int gap;
      gap = $urandom % 4;
      repeat (gap) @(negedge bus);
   endtask

   task automatic writeCommand(input axiAddr_t addr, input regWord_t data, input axiResp_t resp);
      int delay;
      if (bvalid) begin
         $display("Write response showed up before its request");
         testErrors++;
      end
      @(posedge bus);
      #1;
      awaddr  = addr;
      wdata   = data;
      awvalid = 1'b1;
      wvalid  = 1'b1;
      @(negedge bus);
      while (!(awready && wready)) @(negedge bus);
      @(posedge bus); // AW and W accepted here
      #1;
      awvalid = 1'b0;
      wvalid  = 1'b0;
      delay   = $urandom % 4;
      repeat (delay) begin
         @(posedge bus);
         #1;
      end
      bready = 1'b1;
      @(negedge bus);
      if (!bvalid) begin
         $display("Write response not valid while bready was high");
         testErrors++;
      end
      checkResp("bresp", bresp, resp);
      @(posedge bus);
      #1 bready = 1'b0;
      @(negedge bus);
      if (bvalid) begin
         $display("Write response returned more than once");
         testErrors++;
      end
   endtask

   task automatic readCommand(input axiAddr_t addr, input regWord_t data, input axiResp_t resp);
      int delay;
      if (rvalid) begin
         $display("Read response showed up before its request");
         testErrors++;
      end
      @(posedge bus);
      #1;
      araddr  = addr;
      arvalid = 1'b1;
      @(negedge bus);
      while (!arready) @(negedge bus); // Held off while the pipe drains
      @(posedge bus);
      #1 arvalid = 1'b0;
      delay = $urandom % 4;
      repeat (delay) begin
         @(posedge bus);
         #1;
      end
      rready = 1'b1;
      @(negedge bus);
      if (!rvalid) begin
         $display("Read response not valid while rready was high");
         testErrors++;
      end
      checkReg("rdata", rdata, data);
      checkResp("rresp", rresp, resp);
      @(posedge bus);
      #1 rready = 1'b0;
      @(negedge bus);
      if (rvalid) begin
         $display("Read response returned more than once");
         testErrors++;
      end
   endtask

   initial begin
      bit ok;
      awaddr  = '0;
      awvalid = 1'b0;
      wdata   = '0;
      wstrb   = '1;
      wvalid  = 1'b0;
      bready  = 1'b0;
      araddr  = '0;
      arvalid = 1'b0;
      rready  = 1'b0;
      void'($urandom(32'hb84f));
      loadCommands(ok);
      if (!ok) begin
         $display("Could not open tb/coreInput.txt");
         $display("Result: FAILED");
         $finish;
      end else begin
         cycleLimit = cmdKind.size() * 40;
         @(negedge rst);
         for (int i = 0; i < cmdKind.size(); i++) begin
            testErrors = 0;
            idleCycles();
            if (cmdKind[i] == "W") begin
               writeCommand(cmdAddr[i], cmdData[i], cmdResp[i]);
            end else begin
               readCommand(cmdAddr[i], cmdData[i], cmdResp[i]);
            end
            if (testErrors == 0) begin
               $display("Test %0d %c addr %h: ok", i, cmdKind[i], cmdAddr[i]);
            end else begin
               $display("Test %0d %c addr %h: failed", i, cmdKind[i], cmdAddr[i]);
               failedTests++;
            end
         end
         $display("Tests run: %0d, failed: %0d", cmdKind.size(), failedTests);
         if (failedTests == 0) begin
            $display("Result: PASSED");
         end else begin
            $display("Result: FAILED");
         end
         $finish;
      end
   end

endmodule

`default_nettype wire

// File: tb/clockGen.sv
// Testbench clock and reset
`timescale 1ns/1ps
`default_nettype none

module clockGen (
   output logic bus,
   output logic rst
);

   initial begin
      bus = 1'b0;
      forever #10 bus = ~bus; // 20 ns period
   end

   initial begin
      rst = 1'b1;
      repeat (2) @(posedge bus);
      #1 rst = 1'b0;
   end

endmodule

`default_nettype wire

// File: source/core.sv
// Pipelined core top level
`timescale 1ns/1ps
`default_nettype none

`include "coreSettings.svh"

module core
   import corePkg::*;
(
   input  logic                     bus,
   input  logic                     rst,
   input  axiAddr_t                 awaddr,
   input  logic                     awvalid,
   output logic                     awready,
   input  regWord_t                 wdata,
   input  logic [`DATA_WIDTH/8-1:0] wstrb,
   input  logic                     wvalid,
   output logic                     wready,
   output axiResp_t                 bresp,
   output logic                     bvalid,
   input  logic                     bready,
   input  axiAddr_t                 araddr,
   input  logic                     arvalid,
   output logic                     arready,
   output regWord_t                 rdata,
   output axiResp_t                 rresp,
   output logic                     rvalid,
   input  logic                     rready
);

   logic         instrValid, decodeStall, decodeBusy, executeBusy, pipeBusy;
   instrWord_t   instr;
   logic         opValid, resValid, wbValid;
   aluOp_t       aluOp;
   regIndex_t    destReg, srcReg, resDest, wbDest, srcIndex, destIndex, readIndex;
   imm_t         imm;
   regWord_t     resValue, srcValue, destValue, readValue;
   retireCount_t retired;

   assign pipeBusy = instrValid | decodeBusy | executeBusy; // Any stage still holding work

   hostPort host (
      .bus(bus), .rst(rst),
      .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
      .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
      .bresp(bresp), .bvalid(bvalid), .bready(bready),
      .araddr(araddr), .arvalid(arvalid), .arready(arready),
      .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
      .pipeBusy(pipeBusy), .decodeStall(decodeStall),
      .readValue(readValue), .retired(retired),
      .instrValid(instrValid), .instr(instr), .readIndex(readIndex)
   );

   decodeStage decode (
      .bus(bus), .rst(rst), .instrValid(instrValid), .instr(instr),
      .wbValid(wbValid), .wbDest(wbDest), .decodeStall(decodeStall),
      .opValid(opValid), .aluOp(aluOp), .destReg(destReg), .srcReg(srcReg),
      .imm(imm), .busy(decodeBusy)
   );

   executeStage execute (
      .bus(bus), .rst(rst), .opValid(opValid), .aluOp(aluOp),
      .destReg(destReg), .srcReg(srcReg), .imm(imm),
      .srcValue(srcValue), .destValue(destValue),
      .srcIndex(srcIndex), .destIndex(destIndex),
      .resValid(resValid), .resDest(resDest), .resValue(resValue), .busy(executeBusy)
   );

   writeBack result (
      .bus(bus), .rst(rst), .resValid(resValid), .resDest(resDest), .resValue(resValue),
      .srcIndex(srcIndex), .destIndex(destIndex), .readIndex(readIndex),
      .srcValue(srcValue), .destValue(destValue), .readValue(readValue),
      .wbValid(wbValid), .wbDest(wbDest), .retired(retired)
   );

endmodule

`default_nettype wire

// File: source/writeBack.sv
// Register file and retire counter
`timescale 1ns/1ps
`default_nettype none

`include "coreSettings.svh"

module writeBack
   import corePkg::*;
(
   input  logic         bus,
   input  logic         rst,
   input  logic         resValid,
   input  regIndex_t    resDest,
   input  regWord_t     resValue,
   input  regIndex_t    srcIndex,
   input  regIndex_t    destIndex,
   input  regIndex_t    readIndex,
   output regWord_t     srcValue,
   output regWord_t     destValue,
   output regWord_t     readValue,
   output logic         wbValid,
   output regIndex_t    wbDest,
   output retireCount_t retired
);

   regWord_t regFile [`REG_COUNT];

   assign srcValue  = regFile[srcIndex];
   assign destValue = regFile[destIndex];
   assign readValue = regFile[readIndex]; // Host read port

   // Scoreboard release on the write edge
   assign wbValid = resValid;
   assign wbDest  = resDest;

   always_ff @(posedge bus) begin
      if (rst) begin
         for (int i = 0; i < `REG_COUNT; i++) begin
            regFile[i] <= '0;
         end
         retired <= '0;
      end else if (resValid) begin
         regFile[resDest] <= resValue;
         retired          <= retired + 1;
      end
   end

endmodule

`default_nettype wire

// File: source/executeStage.sv
// Operand read and ALU
`timescale 1ns/1ps
`default_nettype none

`include "coreSettings.svh"

module executeStage
   import corePkg::*;
(
   input  logic      bus,
   input  logic      rst,
   input  logic      opValid,
   input  aluOp_t    aluOp,
   input  regIndex_t destReg,
   input  regIndex_t srcReg,
   input  imm_t      imm,
   input  regWord_t  srcValue,
   input  regWord_t  destValue,
   output regIndex_t srcIndex,
   output regIndex_t destIndex,
   output logic      resValid,
   output regIndex_t resDest,
   output regWord_t  resValue,
   output logic      busy
);

   regWord_t immExt;
   regWord_t aluResult;

   assign srcIndex  = srcReg;
   assign destIndex = destReg;
   assign immExt    = {{(`DATA_WIDTH - 16){imm[15]}}, imm};
   assign busy      = resValid;

   always_comb begin
      aluResult = immExt;
      case (aluOp)
         aluMovi: aluResult = immExt;
         aluAdd:  aluResult = destValue + srcValue; // dest op src
         aluSub:  aluResult = destValue - srcValue;
         aluAnd:  aluResult = destValue & srcValue;
         aluOr:   aluResult = destValue | srcValue;
         aluXor:  aluResult = destValue ^ srcValue;
         aluAddi: aluResult = srcValue + immExt; // src plus immediate
         aluShli: aluResult = srcValue << imm[5:0];
         default: aluResult = immExt;
      endcase
   end

   always_ff @(posedge bus) begin
      if (rst) begin
         resValid <= 1'b0;
      end else begin
         resValid <= opValid;
      end
   end

   always_ff @(posedge bus) begin
      if (opValid) begin
         resDest  <= destReg;
         resValue <= aluResult;
      end
   end

endmodule

`default_nettype wire

// File: source/decodeStage.sv
// Instruction decode and scoreboard
`timescale 1ns/1ps
`default_nettype none

`include "coreSettings.svh"

module decodeStage
   import corePkg::*;
(
   input  logic       bus,
   input  logic       rst,
   input  logic       instrValid,
   input  instrWord_t instr,
   input  logic       wbValid,
   input  regIndex_t  wbDest,
   output logic       decodeStall,
   output logic       opValid,
   output aluOp_t     aluOp,
   output regIndex_t  destReg,
   output regIndex_t  srcReg,
   output imm_t       imm,
   output logic       busy
);

   logic [`REG_COUNT-1:0] inUse;
   logic [7:0]            opcode;
   regIndex_t             fieldDest;
   regIndex_t             fieldSrc;
   aluOp_t                opDecoded;
   logic                  known;
   logic                  hazard;
   logic                  issue;

   assign opcode    = instr[31:24];
   assign fieldDest = instr[23:20];
   assign fieldSrc  = instr[19:16];

   always_comb begin
      known     = 1'b1;
      opDecoded = aluMovi;
      case (opcode)
         `OP_MOVI: opDecoded = aluMovi;
         `OP_ADD:  opDecoded = aluAdd;
         `OP_SUB:  opDecoded = aluSub;
         `OP_AND:  opDecoded = aluAnd;
         `OP_OR:   opDecoded = aluOr;
         `OP_XOR:  opDecoded = aluXor;
         `OP_ADDI: opDecoded = aluAddi;
         `OP_SHLI: opDecoded = aluShli;
         default:  known = 1'b0; // Dropped without issue
      endcase
   end

   assign hazard      = inUse[fieldDest] | (inUse[fieldSrc] & (opDecoded != aluMovi));
   assign decodeStall = instrValid & known & hazard;
   assign issue       = instrValid & known & ~hazard;
   assign busy        = opValid;

   always_ff @(posedge bus) begin
      if (rst) begin
         inUse   <= '0;
         opValid <= 1'b0;
      end else begin
         opValid <= issue;
         if (wbValid) begin
            inUse[wbDest] <= 1'b0;
         end
         if (issue) begin
            inUse[fieldDest] <= 1'b1; // Wins over a release of the same register
         end
      end
   end

   always_ff @(posedge bus) begin
      if (issue) begin
         aluOp   <= opDecoded;
         destReg <= fieldDest;
         srcReg  <= fieldSrc;
         imm     <= instr[15:0];
      end
   end

endmodule

`default_nettype wire

// File: source/hostPort.sv
// AXI4-Lite host port
`timescale 1ns/1ps
`default_nettype none

`include "coreSettings.svh"

module hostPort
   import corePkg::*;
(
   input  logic                     bus,
   input  logic                     rst,
   input  axiAddr_t                 awaddr,
   input  logic                     awvalid,
   output logic                     awready,
   input  regWord_t                 wdata,
   input  logic [`DATA_WIDTH/8-1:0] wstrb,
   input  logic                     wvalid,
   output logic                     wready,
   output axiResp_t                 bresp,
   output logic                     bvalid,
   input  logic                     bready,
   input  axiAddr_t                 araddr,
   input  logic                     arvalid,
   output logic                     arready,
   output regWord_t                 rdata,
   output axiResp_t                 rresp,
   output logic                     rvalid,
   input  logic                     rready,
   input  logic                     pipeBusy,
   input  logic                     decodeStall,
   input  regWord_t                 readValue,
   input  retireCount_t             retired,
   output logic                     instrValid,
   output instrWord_t               instr,
   output regIndex_t                readIndex
);

   logic       wrAccept;
   logic       rdAccept;
   logic       instrHit;
   logic       isRegAddr;
   axiAddr_t   regOffset;
   instrWord_t wrWord;

   assign wrAccept = awvalid & wvalid & ~instrValid & ~bvalid; // AW and W taken together
   assign awready  = wrAccept;
   assign wready   = wrAccept;
   assign instrHit = (awaddr == `INSTR_ADDR);

   assign arready   = ~rvalid & ~pipeBusy; // Reads wait for an empty pipe
   assign rdAccept  = arvalid & arready;
   assign regOffset = araddr - `REG_BASE;
   assign isRegAddr = (regOffset < axiAddr_t'(8 * `REG_COUNT)) && (regOffset[2:0] == 3'b000);
   assign readIndex = regOffset[`REG_ADDR_WIDTH+2:3];

   always_comb begin
      for (int i = 0; i < `INSTR_WIDTH / 8; i++) begin
         wrWord[8*i +: 8] = wstrb[i] ? wdata[8*i +: 8] : 8'h00; // Unstrobed bytes read as zero
      end
   end

   always_ff @(posedge bus) begin
      if (rst) begin
         bvalid     <= 1'b0;
         rvalid     <= 1'b0;
         instrValid <= 1'b0;
      end else begin
         if (wrAccept) begin
            bvalid <= 1'b1;
         end else if (bready) begin
            bvalid <= 1'b0;
         end
         if (rdAccept) begin
            rvalid <= 1'b1;
         end else if (rready) begin
            rvalid <= 1'b0;
         end
         if (wrAccept && instrHit) begin
            instrValid <= 1'b1;
         end else if (!decodeStall) begin
            instrValid <= 1'b0; // Taken by decode
         end
      end
   end

   always_ff @(posedge bus) begin
      if (wrAccept) begin
         bresp <= instrHit ? `RESP_OKAY : `RESP_SLVERR;
         if (instrHit) begin
            instr <= wrWord;
         end
      end
      if (rdAccept) begin
         if (isRegAddr) begin
            rdata <= readValue;
            rresp <= `RESP_OKAY;
         end else if (araddr == `RETIRED_ADDR) begin
            rdata <= regWord_t'(retired);
            rresp <= `RESP_OKAY;
         end else begin
            rdata <= '0;
            rresp <= `RESP_SLVERR;
         end
      end
   end

endmodule

`default_nettype wire

// File: source/corePkg.sv
// Core types
`default_nettype none

`include "coreSettings.svh"

package corePkg;

   typedef logic [`DATA_WIDTH-1:0]     regWord_t;
   typedef logic [`REG_ADDR_WIDTH-1:0] regIndex_t;
   typedef logic [`INSTR_WIDTH-1:0]    instrWord_t;
   typedef logic [15:0]                imm_t;
   typedef logic [`AXI_ADDR_WIDTH-1:0] axiAddr_t;
   typedef logic [1:0]                 axiResp_t;
   typedef logic [31:0]                retireCount_t;

   typedef enum logic [2:0] {
      aluMovi,
      aluAdd,
      aluSub,
      aluAnd,
      aluOr,
      aluXor,
      aluAddi,
      aluShli
   } aluOp_t;

endpackage

`default_nettype wire

// File: source/coreSettings.svh
// Core widths, address map and opcodes
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

`define DATA_WIDTH      64
`define REG_COUNT       16
`define REG_ADDR_WIDTH  4
`define INSTR_WIDTH     32
`define AXI_ADDR_WIDTH  8

`define INSTR_ADDR      8'h00  // Instruction push
`define REG_BASE        8'h00  // Register n at REG_BASE + 8*n
`define RETIRED_ADDR    8'h80

`define RESP_OKAY       2'b00
`define RESP_SLVERR     2'b10

`define OP_MOVI  8'hB8
`define OP_ADD   8'h01
`define OP_SUB   8'h29
`define OP_AND   8'h21
`define OP_OR    8'h09
`define OP_XOR   8'h31
`define OP_ADDI  8'h05
`define OP_SHLI  8'hC1

`endif
